// File: Makefile
# Verilator flow for the busy table subsystem.
# Every variable below can be overridden on the make command line.

VERILATOR ?= verilator
TOP       ?= busy_top_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= TEST OK

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only if the pass text shows up in the simulator output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: sources.f
src/rename_cfg_pkg.sv
src/backend_ctrl_pkg.sv
src/busy_set_unit.sv
src/busy_clear_unit.sv
src/busy_table.sv
src/busy_top.sv
verification/busy_top_chk.sv
verification/busy_top_tb.sv

// File: src/backend_ctrl_pkg.sv
`default_nettype none

package backend_ctrl_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pipeline control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // flush request from the backend
    typedef struct packed {
        logic redirect;                                 // younger ops being squashed
    } backend_ctrl_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // rollback walk
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // While walk is high the commit stage steps back through squashed
    // entries and hands their destination registers back as ready.
    typedef struct packed {
        logic                                                     walk;  // walk cycle
        logic [rename_cfg_pkg::commit_width-1:0]                  we;    // lane had a dest
        rename_cfg_pkg::preg_idx_t [rename_cfg_pkg::commit_width-1:0] prd; // preg to restore
    } walk_t;

endpackage

`default_nettype wire

// File: src/busy_clear_unit.sv
`timescale 1ns/10ps
`default_nettype none

module busy_clear_unit (
    input  wire rename_cfg_pkg::wakeup_t   wakeup,
    input  wire backend_ctrl_pkg::walk_t   walk,
    output rename_cfg_pkg::preg_mask_t     wb_mask,
    output rename_cfg_pkg::preg_mask_t     walk_mask
);

    // writeback side
    logic [rename_cfg_pkg::wb_size-1:0]                        wb_live;
    rename_cfg_pkg::preg_mask_t [rename_cfg_pkg::wb_size-1:0]  wb_lane_mask;

    // walk side
    logic [rename_cfg_pkg::commit_width-1:0]                       walk_live;
    rename_cfg_pkg::preg_mask_t [rename_cfg_pkg::commit_width-1:0] walk_lane_mask;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // writeback wakeup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign wb_live = wakeup.en & wakeup.we;             // result actually written

    for (genvar i = 0; i < rename_cfg_pkg::wb_size; i++) begin : g_wb
        rename_cfg_pkg::preg_mask_t onehot;

        assign onehot          = rename_cfg_pkg::preg_mask_t'(1) << wakeup.rd[i];
        assign wb_lane_mask[i] = onehot
                               & {rename_cfg_pkg::preg_size{wb_live[i]}};
    end

    always_comb begin
        wb_mask = '0;
        for (int i = 0; i < rename_cfg_pkg::wb_size; i++) begin
            wb_mask = wb_mask | wb_lane_mask[i];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // rollback walk restore
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Walk lanes carry the destinations of squashed ops. They are only
    // meaningful while the walk flag is up.
    assign walk_live = walk.we & {rename_cfg_pkg::commit_width{walk.walk}};

    for (genvar i = 0; i < rename_cfg_pkg::commit_width; i++) begin : g_walk
        rename_cfg_pkg::preg_mask_t onehot;

        assign onehot            = rename_cfg_pkg::preg_mask_t'(1) << walk.prd[i];
        assign walk_lane_mask[i] = onehot
                                 & {rename_cfg_pkg::preg_size{walk_live[i]}};
    end

    // Kept apart from wb_mask. The read ports bypass writeback results
    // but a walk only takes effect in the stored bitmap.
    always_comb begin
        walk_mask = '0;
        for (int i = 0; i < rename_cfg_pkg::commit_width; i++) begin
            walk_mask = walk_mask | walk_lane_mask[i];
        end
    end

endmodule

`default_nettype wire

// File: src/busy_set_unit.sv
`timescale 1ns/10ps
`default_nettype none

module busy_set_unit (
    input  wire rename_cfg_pkg::dispatch_t       dispatch,
    input  wire backend_ctrl_pkg::backend_ctrl_t backend_ctrl,
    output rename_cfg_pkg::preg_mask_t           set_mask
);

    // per-lane decode
    rename_cfg_pkg::preg_mask_t [rename_cfg_pkg::fetch_width-1:0] lane_mask;

    // lanes that really allocate this cycle
    logic [rename_cfg_pkg::fetch_width-1:0] lane_live;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lane qualification
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // A redirect squashes everything in rename, so nothing it dispatches
    // in that cycle may leave a register marked busy.
    assign lane_live = dispatch.en
                     & {rename_cfg_pkg::fetch_width{~backend_ctrl.redirect}};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // destination decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar i = 0; i < rename_cfg_pkg::fetch_width; i++) begin : g_lane
        rename_cfg_pkg::preg_mask_t onehot;

        assign onehot       = rename_cfg_pkg::preg_mask_t'(1) << dispatch.rd[i];  // index to bit
        assign lane_mask[i] = onehot
                            & {rename_cfg_pkg::preg_size{lane_live[i]}};        // drop idle lane
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lane merge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        set_mask = '0;
        for (int i = 0; i < rename_cfg_pkg::fetch_width; i++) begin
            set_mask = set_mask | lane_mask[i];         // lanes never collide in practice
        end
    end

endmodule

`default_nettype wire

// File: src/busy_table.sv
`timescale 1ns/10ps
`default_nettype none

module busy_table #(
    parameter int READ_PORTS = 4
) (
    input  wire                                             clk,
    input  wire                                             rst_n,
    input  wire rename_cfg_pkg::preg_mask_t                 set_mask,
    input  wire rename_cfg_pkg::preg_mask_t                 wb_mask,
    input  wire rename_cfg_pkg::preg_mask_t                 walk_mask,
    input  wire rename_cfg_pkg::preg_idx_t [READ_PORTS-1:0] src_preg,
    output logic [READ_PORTS-1:0]                           src_ready
);

    rename_cfg_pkg::preg_mask_t ready_q;                // stored ready bitmap
    rename_cfg_pkg::preg_mask_t ready_byp;              // bitmap seen by readers
    rename_cfg_pkg::preg_mask_t ready_d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bitmap update
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // this cycle's writebacks count as ready already
    assign ready_byp = ready_q | wb_mask;

    // Clearing goes last. A register reallocated in the same cycle that an
    // older producer of it wakes up belongs to the new producer and must
    // stay busy.
    assign ready_d = (ready_byp | walk_mask) & ~set_mask;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_q <= '1;                              // nothing in flight
        end else begin
            ready_q <= ready_d;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read ports
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        src_ready = '0;
        for (int p = 0; p < READ_PORTS; p++) begin
            src_ready[p] = ready_byp[src_preg[p]];      // walk restores not bypassed
        end
    end

endmodule

`default_nettype wire

// File: src/busy_top.sv
`timescale 1ns/10ps
`default_nettype none

module busy_top #(
    parameter int READ_PORTS = 4
) (
    input  wire                                             clk,
    input  wire                                             rst_n,
    input  wire rename_cfg_pkg::dispatch_t                  dispatch,
    input  wire rename_cfg_pkg::wakeup_t                    wakeup,
    input  wire backend_ctrl_pkg::walk_t                    walk,
    input  wire backend_ctrl_pkg::backend_ctrl_t            backend_ctrl,
    input  wire rename_cfg_pkg::preg_idx_t [READ_PORTS-1:0] src_preg,
    output logic [READ_PORTS-1:0]                           src_ready
);

    rename_cfg_pkg::preg_mask_t set_mask;               // dispatch marks busy
    rename_cfg_pkg::preg_mask_t wb_mask;                // writeback marks ready
    rename_cfg_pkg::preg_mask_t walk_mask;              // rollback walk marks ready

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // mask builders
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    busy_set_unit u_busy_set_unit (
        .dispatch     (dispatch),
        .backend_ctrl (backend_ctrl),
        .set_mask     (set_mask)
    );

    busy_clear_unit u_busy_clear_unit (
        .wakeup    (wakeup),
        .walk      (walk),
        .wb_mask   (wb_mask),
        .walk_mask (walk_mask)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ready bitmap
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    busy_table #(
        .READ_PORTS (READ_PORTS)
    ) u_busy_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .set_mask  (set_mask),
        .wb_mask   (wb_mask),
        .walk_mask (walk_mask),
        .src_preg  (src_preg),
        .src_ready (src_ready)
    );

endmodule

`default_nettype wire

// File: src/rename_cfg_pkg.sv
`default_nettype none

package rename_cfg_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register file and lane sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int preg_size    = 32;                   // physical registers
    localparam int preg_width   = $clog2(preg_size);    // index bits
    localparam int fetch_width  = 2;                    // dispatch lanes
    localparam int wb_size      = 2;                    // writeback lanes
    localparam int commit_width = 2;                    // walk lanes

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register index and mask types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [preg_width-1:0] preg_idx_t;         // one physical register
    typedef logic [preg_size-1:0]  preg_mask_t;        // one bit per register

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lane bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Rename hands over up to fetch_width newly allocated destinations
    // per cycle. Lane i uses en[i] and rd[i].
    typedef struct packed {
        logic      [fetch_width-1:0] en;                // lane has a destination
        preg_idx_t [fetch_width-1:0] rd;                // allocated preg
    } dispatch_t;

    // Writeback broadcast. A lane without we produced no register result
    // (stores, branches) and must not wake anything.
    typedef struct packed {
        logic      [wb_size-1:0] en;                    // lane finished
        logic      [wb_size-1:0] we;                    // lane writes a preg
        preg_idx_t [wb_size-1:0] rd;                    // written preg
    } wakeup_t;

endpackage

`default_nettype wire

// File: verification/busy_top_chk.sv
`timescale 1ns/10ps
`default_nettype none

module busy_top_chk #(
    parameter int READ_PORTS = 4
) (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire rename_cfg_pkg::preg_mask_t set_mask,
    input  wire rename_cfg_pkg::preg_mask_t ready_q,
    input  wire [READ_PORTS-1:0]            src_ready
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bitmap properties
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_set_makes_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        (set_mask != '0) |=> ((ready_q & $past(set_mask)) == '0)    // dispatch wins
    ) else $error("dispatched register still marked ready in the bitmap");

    a_reset_all_ready : assert property (
        @(posedge clk)
        ($rose(rst_n) && (set_mask == '0)) |=> (ready_q == '1)
    ) else $error("bitmap not all ready one cycle after reset release");

    a_ready_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(src_ready)
    ) else $error("src_ready has unknown bits");

endmodule

bind busy_table busy_top_chk #(
    .READ_PORTS (READ_PORTS)
) u_busy_top_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .set_mask  (set_mask),
    .ready_q   (ready_q),
    .src_ready (src_ready)
);

`default_nettype wire

// File: verification/busy_top_tb.sv
`timescale 1ns/10ps
`default_nettype none

module busy_top_tb;

    localparam int READ_PORTS   = 4;
    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 4;
    localparam int MARGIN       = 20;                   // spare cycles for the watchdog
    localparam int FIELDS       = 10;                   // hex words per vector line
    localparam int MAX_VECS     = 64;
    localparam logic [31:0] END_MARK = 32'hff;
    localparam string VEC_FILE  = "verification/busy_vectors.txt";

    logic                                       clk;
    logic                                       rst_n;
    rename_cfg_pkg::dispatch_t                  dispatch;
    rename_cfg_pkg::wakeup_t                    wakeup;
    backend_ctrl_pkg::walk_t                    walk;
    backend_ctrl_pkg::backend_ctrl_t            backend_ctrl;
    rename_cfg_pkg::preg_idx_t [READ_PORTS-1:0] src_preg;
    logic [READ_PORTS-1:0]                      src_ready;

    logic [31:0] vec_mem [0:FIELDS*MAX_VECS-1];
    int          n_vec;
    bit          vectors_ready;
    int          total_checks;
    int          total_errors;
    int          test_count;

    busy_top #(
        .READ_PORTS (READ_PORTS)
    ) u_busy_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .dispatch     (dispatch),
        .wakeup       (wakeup),
        .walk         (walk),
        .backend_ctrl (backend_ctrl),
        .src_preg     (src_preg),
        .src_ready    (src_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // vector handling
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic load_vectors();
        int i;
        $readmemh(VEC_FILE, vec_mem);
        n_vec = -1;                                     // stays negative without end mark
        for (i = 0; i < MAX_VECS; i++) begin
            if (n_vec < 0 && vec_mem[i*FIELDS] == END_MARK) begin
                n_vec = i;
            end
        end
    endtask

    task automatic drive_idle();
        dispatch              = '0;
        wakeup                = '0;
        walk                  = '0;
        backend_ctrl.redirect = 1'b0;
        src_preg              = '0;
    endtask

    task automatic apply_vector(input int idx);
        int base;
        base                  = idx * FIELDS;
        dispatch              = vec_mem[base + 1][$bits(rename_cfg_pkg::dispatch_t)-1:0];
        wakeup                = vec_mem[base + 2][$bits(rename_cfg_pkg::wakeup_t)-1:0];
        walk                  = vec_mem[base + 3][$bits(backend_ctrl_pkg::walk_t)-1:0];
        backend_ctrl.redirect = vec_mem[base + 4][0];
        for (int p = 0; p < READ_PORTS; p++) begin
            src_preg[p] = vec_mem[base + 5 + p][rename_cfg_pkg::preg_width-1:0];
        end
    endtask

    task automatic check_vector(input int idx, output bit ok);
        logic [READ_PORTS-1:0] expected;
        expected = vec_mem[idx*FIELDS + 9][READ_PORTS-1:0];
        ok       = 1'b1;
        assert (src_ready === expected)
        else begin
            $display("** Error src_ready: test %0d line %0d expected %h actual %h",
                     vec_mem[idx*FIELDS][7:0], idx, expected, src_ready);
            ok = 1'b0;
        end
    endtask

    task automatic report_test(input int test, input int checks, input int errors);
        if (errors == 0) begin
            $display("test %0d passed, %0d cycles checked", test, checks);
        end else begin
            $display("test %0d had %0d errors in %0d cycles", test, errors, checks);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int cur_test;
        int test_checks;
        int test_errors;
        bit ok;
        rst_n         = 1'b0;
        vectors_ready = 1'b0;
        total_checks  = 0;
        total_errors  = 0;
        test_count    = 0;
        cur_test      = -1;
        test_checks   = 0;
        test_errors   = 0;
        drive_idle();
        load_vectors();
        vectors_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        if (n_vec <= 0) begin
            $display("vector file has no vectors or no end marker");
            total_errors++;
        end

        for (int idx = 0; idx < n_vec; idx++) begin
            @(negedge clk);
            if (int'(vec_mem[idx*FIELDS][7:0]) != cur_test) begin
                if (cur_test >= 0) begin
                    report_test(cur_test, test_checks, test_errors);
                end
                cur_test    = int'(vec_mem[idx*FIELDS][7:0]);
                test_checks = 0;
                test_errors = 0;
                test_count++;
            end
            apply_vector(idx);
            #(PERIOD/2 - 1);                            // just ahead of the rising edge
            check_vector(idx, ok);
            test_checks++;
            total_checks++;
            if (!ok) begin
                test_errors++;
                total_errors++;
            end
        end
        if (cur_test >= 0) begin
            report_test(cur_test, test_checks, test_errors);
        end

        $display("tests %0d, checks %0d, errors %0d", test_count, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        wait (vectors_ready);
        #((n_vec + RESET_CYCLES + MARGIN) * PERIOD);
        $display("run timed out, vectors did not finish within %0d cycles",
                 n_vec + RESET_CYCLES + MARGIN);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/busy_vectors.txt
// test dispatch wakeup walk redirect src0 src1 src2 src3 ready, one cycle per line, all hex
// ready bit p belongs to src port p, a line with test ff ends the list
01 000 0000 0000 0 00 01 02 03 f
01 000 0000 0000 0 0a 10 1e 1f f
01 000 0000 0000 0 05 0c 13 1b f
// dispatch busies 03, 09, then 14
02 d23 0000 0000 0 03 09 04 00 f
02 000 0000 0000 0 03 09 04 00 c
02 414 0000 0000 0 03 14 09 1f a
02 000 0000 0000 0 14 03 09 15 8
02 000 0000 0000 0 14 03 09 15 8
// wakeup bypass, lanes without we ignored
03 000 1403 0000 0 03 09 14 00 9
03 000 0000 0000 0 03 09 14 00 9
03 000 1009 0000 0 09 03 14 00 a
03 000 3a89 0000 0 14 09 03 1f d
03 000 0000 0000 0 14 09 03 1f d
// redirect squashes dispatch
04 cc5 0000 0000 1 05 06 09 00 b
04 000 0000 0000 0 05 06 09 00 b
04 8c5 0000 0000 0 05 06 09 00 b
04 000 0000 0000 0 05 06 09 00 9
// walk restores at the next edge only
05 000 0000 1409 0 09 06 00 01 c
05 000 0000 0000 0 09 06 00 01 d
05 000 0000 1006 0 09 06 00 01 d
05 000 0000 0406 0 09 06 00 01 d
05 000 0000 0000 0 09 06 00 01 d
05 000 0000 18c0 0 09 06 00 01 d
05 000 0000 0000 0 09 06 00 01 f
// dispatch against same-cycle wakeup and walk
06 411 0000 0000 0 11 12 00 1f f
06 000 0000 0000 0 11 12 00 1f e
06 a20 1411 0000 0 11 12 00 1f f
06 000 0000 0000 0 11 12 00 1f e
06 412 0000 1412 0 11 12 00 1f e
06 000 0000 0000 0 11 12 00 1f c
06 000 3e51 0000 0 11 12 00 1f f
06 000 0000 0000 0 11 12 00 1f f
ff 000 0000 0000 0 00 00 00 00 0
